//--- source/dhs_pkg.sv
package dhs_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths and address map
  ////////////////////////////////////////////////////////////

  localparam int DHS_ADDRW   = 32;
  localparam int DHS_DATAW   = 32;
  localparam int REGION_BITS = 12;
  localparam int REGION_TAGW = DHS_ADDRW - REGION_BITS;

  localparam logic [DHS_ADDRW-1:0] SYS_CTRL_BASE = 32'h1000_0000;
  localparam logic [DHS_ADDRW-1:0] UART_BASE     = 32'h1000_1000;

  // Upper address bits that select a 4 KiB region
  localparam logic [REGION_TAGW-1:0] SYS_CTRL_TAG = SYS_CTRL_BASE[DHS_ADDRW-1:REGION_BITS];
  localparam logic [REGION_TAGW-1:0] UART_TAG     = UART_BASE[DHS_ADDRW-1:REGION_BITS];

  localparam logic [DHS_DATAW-1:0] SOC_ID = 32'hD0A1_4E11;

  // Register offsets inside a region
  localparam logic [REGION_BITS-1:0] SYS_ID_OFS       = 12'h000;
  localparam logic [REGION_BITS-1:0] SYS_SCRATCH0_OFS = 12'h004;
  localparam logic [REGION_BITS-1:0] SYS_SCRATCH1_OFS = 12'h008;
  localparam logic [REGION_BITS-1:0] UART_DATA_OFS    = 12'h000;
  localparam logic [REGION_BITS-1:0] UART_STATUS_OFS  = 12'h004;

  ////////////////////////////////////////////////////////////
  // UART bit timing
  ////////////////////////////////////////////////////////////

  localparam int UART_CLKS_PER_BIT = 8;
  localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

  localparam logic [UART_CNT_W-1:0] UART_BIT_LAST = UART_CNT_W'(UART_CLKS_PER_BIT - 1);
  localparam logic [UART_CNT_W-1:0] UART_BIT_MID  = UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    DEV_SYS_CTRL,
    DEV_UART,
    DEV_NONE
  } dev_sel_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } uart_state_e;

endpackage

//--- source/uart_tx.sv
module uart_tx (
  input  logic       periphl_clk_i,
  input  logic       rst_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_busy_o,
  output logic       tx_o
);

  dhs_pkg::uart_state_e            state_q;
  logic [dhs_pkg::UART_CNT_W-1:0]  baud_q;
  logic [2:0]                      bit_q;
  logic [7:0]                      shift_q;
  logic                            bit_end;

  assign bit_end   = (baud_q == dhs_pkg::UART_BIT_LAST);
  assign tx_busy_o = (state_q != dhs_pkg::ST_IDLE);

  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      state_q <= dhs_pkg::ST_IDLE;
      baud_q  <= '0;
      bit_q   <= '0;
      tx_o    <= 1'b1;
    end else begin
      baud_q <= (bit_end || !tx_busy_o) ? '0 : baud_q + 1'b1;
      case (state_q)
        dhs_pkg::ST_IDLE: begin
          if (tx_start_i) begin
            state_q <= dhs_pkg::ST_START;
            tx_o    <= 1'b0;
          end
        end
        dhs_pkg::ST_START: begin
          if (bit_end) begin
            state_q <= dhs_pkg::ST_DATA;
            bit_q   <= '0;
            tx_o    <= shift_q[0];
          end
        end
        dhs_pkg::ST_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= dhs_pkg::ST_STOP;
              tx_o    <= 1'b1;
            end else begin
              tx_o <= shift_q[1];
            end
          end
        end
        default: begin
          // Busy drops as the stop bit ends
          if (bit_end) begin
            state_q <= dhs_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  // Frame byte, LSB first
  always_ff @(posedge periphl_clk_i) begin
    if ((state_q == dhs_pkg::ST_IDLE) && tx_start_i) begin
      shift_q <= tx_data_i;
    end else if ((state_q == dhs_pkg::ST_DATA) && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  a_idle_line_high: assert property (
    @(posedge periphl_clk_i) disable iff (rst_i) (state_q == dhs_pkg::ST_IDLE) |-> tx_o
  ) else $error("serial line low while transmitter idle");

endmodule

//--- source/uart_rx.sv
module uart_rx (
  input  logic       periphl_clk_i,
  input  logic       rst_i,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_data_o
);

  dhs_pkg::uart_state_e            state_q;
  logic [dhs_pkg::UART_CNT_W-1:0]  baud_q;
  logic [2:0]                      bit_q;
  logic [2:0]                      sync_q;
  logic                            rx_s;
  logic                            rx_fall;

  // Two synchronizer stages, the third flop only keeps the last level
  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[1:0], rx_i};
    end
  end

  assign rx_s    = sync_q[1];
  assign rx_fall = sync_q[2] && !sync_q[1];

  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      state_q    <= dhs_pkg::ST_IDLE;
      baud_q     <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      baud_q     <= baud_q + 1'b1;
      case (state_q)
        dhs_pkg::ST_IDLE: begin
          baud_q <= '0;
          if (rx_fall) begin
            state_q <= dhs_pkg::ST_START;
          end
        end
        dhs_pkg::ST_START: begin
          // Mid-bit check filters glitches on the line
          if (baud_q == dhs_pkg::UART_BIT_MID) begin
            baud_q  <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? dhs_pkg::ST_IDLE : dhs_pkg::ST_DATA;
          end
        end
        dhs_pkg::ST_DATA: begin
          if (baud_q == dhs_pkg::UART_BIT_LAST) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= dhs_pkg::ST_STOP;
            end
          end
        end
        default: begin
          if (baud_q == dhs_pkg::UART_BIT_LAST) begin
            rx_valid_o <= rx_s;
            state_q    <= dhs_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if ((state_q == dhs_pkg::ST_DATA) && (baud_q == dhs_pkg::UART_BIT_LAST)) begin
      rx_data_o <= {rx_s, rx_data_o[7:1]};
    end
  end

endmodule

//--- source/uart_regs.sv
module uart_regs (
  input  logic                             periphl_clk_i,
  input  logic                             rst_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [dhs_pkg::REGION_BITS-1:0]  addr_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]    wdata_i,
  output logic                             rsp_valid_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]    rsp_rdata_o,
  output logic                             rsp_err_o,
  input  logic                             uart_rx_i,
  output logic                             uart_tx_o
);

  logic                          tx_start;
  logic                          tx_busy;
  logic                          rx_valid;
  logic [7:0]                    rx_data;
  logic [7:0]                    rx_byte_q;
  logic                          rx_full_q;
  logic                          rx_clr;
  logic [dhs_pkg::DHS_DATAW-1:0] rd_data;
  logic                          acc_err;

  always_comb begin
    rd_data  = '0;
    acc_err  = 1'b0;
    tx_start = 1'b0;
    rx_clr   = 1'b0;
    case (addr_i)
      dhs_pkg::UART_DATA_OFS: begin
        if (we_i) begin
          // Refused while a frame is on the line
          acc_err  = tx_busy;
          tx_start = req_i && !tx_busy;
        end else begin
          rd_data = {{(dhs_pkg::DHS_DATAW - 8){1'b0}}, rx_byte_q};
          rx_clr  = req_i;
        end
      end
      dhs_pkg::UART_STATUS_OFS: begin
        rd_data = {{(dhs_pkg::DHS_DATAW - 2){1'b0}}, rx_full_q, tx_busy};
        acc_err = we_i;
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      rx_full_q   <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
      rsp_err_o   <= req_i && acc_err;
      // A new byte wins over a read in the same cycle
      if (rx_valid) begin
        rx_full_q <= 1'b1;
      end else if (rx_clr) begin
        rx_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (req_i) begin
      rsp_rdata_o <= rd_data;
    end
    if (rx_valid) begin
      rx_byte_q <= rx_data;
    end
  end

  uart_tx i_uart_tx (
    .periphl_clk_i (periphl_clk_i),
    .rst_i         (rst_i),
    .tx_start_i    (tx_start),
    .tx_data_i     (wdata_i[7:0]),
    .tx_busy_o     (tx_busy),
    .tx_o          (uart_tx_o)
  );

  uart_rx i_uart_rx (
    .periphl_clk_i (periphl_clk_i),
    .rst_i         (rst_i),
    .rx_i          (uart_rx_i),
    .rx_valid_o    (rx_valid),
    .rx_data_o     (rx_data)
  );

endmodule

//--- source/sys_ctrl.sv
module sys_ctrl (
  input  logic                             periphl_clk_i,
  input  logic                             rst_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [dhs_pkg::REGION_BITS-1:0]  addr_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]    wdata_i,
  output logic                             rsp_valid_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]    rsp_rdata_o,
  output logic                             rsp_err_o
);

  logic [dhs_pkg::DHS_DATAW-1:0] scratch0_q;
  logic [dhs_pkg::DHS_DATAW-1:0] scratch1_q;
  logic [dhs_pkg::DHS_DATAW-1:0] rd_data;
  logic                          acc_err;

  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (addr_i)
      dhs_pkg::SYS_ID_OFS: begin
        rd_data = dhs_pkg::SOC_ID;
        acc_err = we_i;  // identity word is read-only
      end
      dhs_pkg::SYS_SCRATCH0_OFS: rd_data = scratch0_q;
      dhs_pkg::SYS_SCRATCH1_OFS: rd_data = scratch1_q;
      default:                   acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      scratch0_q  <= '0;
      scratch1_q  <= '0;
    end else begin
      rsp_valid_o <= req_i;
      rsp_err_o   <= req_i && acc_err;
      if (req_i && we_i && (addr_i == dhs_pkg::SYS_SCRATCH0_OFS)) begin
        scratch0_q <= wdata_i;
      end
      if (req_i && we_i && (addr_i == dhs_pkg::SYS_SCRATCH1_OFS)) begin
        scratch1_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (req_i) begin
      rsp_rdata_o <= rd_data;
    end
  end

endmodule

//--- source/periph_link.sv
module periph_link (
  input  logic                             periphl_clk_i,
  input  logic                             rst_i,
  // Upstream bus
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [dhs_pkg::DHS_ADDRW-1:0]    addr_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]    wdata_i,
  output logic                             rsp_valid_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]    rsp_rdata_o,
  output logic                             rsp_err_o,
  // System controller
  output logic                             sys_req_o,
  output logic                             sys_we_o,
  output logic [dhs_pkg::REGION_BITS-1:0]  sys_addr_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]    sys_wdata_o,
  input  logic                             sys_rsp_valid_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]    sys_rsp_rdata_i,
  input  logic                             sys_rsp_err_i,
  // UART
  output logic                             uart_req_o,
  output logic                             uart_we_o,
  output logic [dhs_pkg::REGION_BITS-1:0]  uart_addr_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]    uart_wdata_o,
  input  logic                             uart_rsp_valid_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]    uart_rsp_rdata_i,
  input  logic                             uart_rsp_err_i
);

  dhs_pkg::dev_sel_e dev_sel;
  dhs_pkg::dev_sel_e sel_q;
  logic              none_err_q;

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (addr_i[dhs_pkg::DHS_ADDRW-1:dhs_pkg::REGION_BITS])
      dhs_pkg::SYS_CTRL_TAG: dev_sel = dhs_pkg::DEV_SYS_CTRL;
      dhs_pkg::UART_TAG:     dev_sel = dhs_pkg::DEV_UART;
      default:               dev_sel = dhs_pkg::DEV_NONE;
    endcase
  end

  assign sys_req_o    = req_i && (dev_sel == dhs_pkg::DEV_SYS_CTRL);
  assign sys_we_o     = we_i;
  assign sys_addr_o   = addr_i[dhs_pkg::REGION_BITS-1:0];
  assign sys_wdata_o  = wdata_i;

  assign uart_req_o   = req_i && (dev_sel == dhs_pkg::DEV_UART);
  assign uart_we_o    = we_i;
  assign uart_addr_o  = addr_i[dhs_pkg::REGION_BITS-1:0];
  assign uart_wdata_o = wdata_i;

  // Unmapped requests are answered here, one cycle later
  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      sel_q      <= dhs_pkg::DEV_NONE;
      none_err_q <= 1'b0;
    end else begin
      none_err_q <= req_i && (dev_sel == dhs_pkg::DEV_NONE);
      if (req_i) begin
        sel_q <= dev_sel;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (sel_q)
      dhs_pkg::DEV_SYS_CTRL: begin
        rsp_valid_o = sys_rsp_valid_i;
        rsp_rdata_o = sys_rsp_rdata_i;
        rsp_err_o   = sys_rsp_err_i;
      end
      dhs_pkg::DEV_UART: begin
        rsp_valid_o = uart_rsp_valid_i;
        rsp_rdata_o = uart_rsp_rdata_i;
        rsp_err_o   = uart_rsp_err_i;
      end
      default: begin
        rsp_valid_o = none_err_q;
        rsp_rdata_o = '0;
        rsp_err_o   = none_err_q;
      end
    endcase
  end

  a_one_responder: assert property (
    @(posedge periphl_clk_i) disable iff (rst_i) !(sys_rsp_valid_i && uart_rsp_valid_i)
  ) else $error("two peripherals answered in the same cycle");

endmodule

//--- source/apb_slave_port.sv
module apb_slave_port (
  input  logic                           periphl_clk_i,
  input  logic                           rst_i,
  // APB slave side
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic [dhs_pkg::DHS_ADDRW-1:0]  paddr_i,
  input  logic                           pwrite_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]  pwdata_i,
  output logic                           pready_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]  prdata_o,
  output logic                           pslverr_o,
  // Register bus requester side
  output logic                           bus_req_o,
  output logic                           bus_we_o,
  output logic [dhs_pkg::DHS_ADDRW-1:0]  bus_addr_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]  bus_wdata_o,
  input  logic                           rsp_valid_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]  rsp_rdata_i,
  input  logic                           rsp_err_i
);

  // Set once the strobe of the current access phase went out
  logic pending_q;

  // First access cycle sends the strobe, the held phase sends nothing more
  assign bus_req_o   = psel_i && penable_i && !pending_q;
  assign bus_we_o    = pwrite_i;
  assign bus_addr_o  = paddr_i;
  assign bus_wdata_o = pwdata_i;

  assign pready_o  = rsp_valid_i;
  assign prdata_o  = rsp_rdata_i;
  assign pslverr_o = rsp_err_i;

  always_ff @(posedge periphl_clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (rsp_valid_i) begin
      pending_q <= 1'b0;
    end else if (bus_req_o) begin
      pending_q <= 1'b1;
    end
  end

  // The response must land inside the access phase that asked for it
  a_pready_in_access: assert property (
    @(posedge periphl_clk_i) disable iff (rst_i) pready_o |-> (psel_i && penable_i)
  ) else $error("pready outside an APB access phase");

endmodule

//--- source/dual_helix_periph.sv
module dual_helix_periph (
  input  logic                           periphl_clk_i,
  input  logic                           rst_i,
  input  logic                           apb_psel_i,
  input  logic                           apb_penable_i,
  input  logic [dhs_pkg::DHS_ADDRW-1:0]  apb_paddr_i,
  input  logic                           apb_pwrite_i,
  input  logic [dhs_pkg::DHS_DATAW-1:0]  apb_pwdata_i,
  output logic                           apb_pready_o,
  output logic [dhs_pkg::DHS_DATAW-1:0]  apb_prdata_o,
  output logic                           apb_pslverr_o,
  input  logic                           uart_rx_i,
  output logic                           uart_tx_o
);

  ////////////////////////////////////////////////////////////
  // Register bus between APB port and link
  ////////////////////////////////////////////////////////////

  logic                            bus_req;
  logic                            bus_we;
  logic [dhs_pkg::DHS_ADDRW-1:0]   bus_addr;
  logic [dhs_pkg::DHS_DATAW-1:0]   bus_wdata;
  logic                            rsp_valid;
  logic [dhs_pkg::DHS_DATAW-1:0]   rsp_rdata;
  logic                            rsp_err;

  // Peripheral side of the link
  logic                            sys_req;
  logic                            sys_we;
  logic [dhs_pkg::REGION_BITS-1:0] sys_addr;
  logic [dhs_pkg::DHS_DATAW-1:0]   sys_wdata;
  logic                            sys_rsp_valid;
  logic [dhs_pkg::DHS_DATAW-1:0]   sys_rsp_rdata;
  logic                            sys_rsp_err;
  logic                            uart_req;
  logic                            uart_we;
  logic [dhs_pkg::REGION_BITS-1:0] uart_addr;
  logic [dhs_pkg::DHS_DATAW-1:0]   uart_wdata;
  logic                            uart_rsp_valid;
  logic [dhs_pkg::DHS_DATAW-1:0]   uart_rsp_rdata;
  logic                            uart_rsp_err;

  apb_slave_port i_apb_slave_port (
    .periphl_clk_i (periphl_clk_i),
    .rst_i         (rst_i),
    .psel_i        (apb_psel_i),
    .penable_i     (apb_penable_i),
    .paddr_i       (apb_paddr_i),
    .pwrite_i      (apb_pwrite_i),
    .pwdata_i      (apb_pwdata_i),
    .pready_o      (apb_pready_o),
    .prdata_o      (apb_prdata_o),
    .pslverr_o     (apb_pslverr_o),
    .bus_req_o     (bus_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_wdata_o   (bus_wdata),
    .rsp_valid_i   (rsp_valid),
    .rsp_rdata_i   (rsp_rdata),
    .rsp_err_i     (rsp_err)
  );

  periph_link i_periph_link (
    .periphl_clk_i    (periphl_clk_i),
    .rst_i            (rst_i),
    .req_i            (bus_req),
    .we_i             (bus_we),
    .addr_i           (bus_addr),
    .wdata_i          (bus_wdata),
    .rsp_valid_o      (rsp_valid),
    .rsp_rdata_o      (rsp_rdata),
    .rsp_err_o        (rsp_err),
    .sys_req_o        (sys_req),
    .sys_we_o         (sys_we),
    .sys_addr_o       (sys_addr),
    .sys_wdata_o      (sys_wdata),
    .sys_rsp_valid_i  (sys_rsp_valid),
    .sys_rsp_rdata_i  (sys_rsp_rdata),
    .sys_rsp_err_i    (sys_rsp_err),
    .uart_req_o       (uart_req),
    .uart_we_o        (uart_we),
    .uart_addr_o      (uart_addr),
    .uart_wdata_o     (uart_wdata),
    .uart_rsp_valid_i (uart_rsp_valid),
    .uart_rsp_rdata_i (uart_rsp_rdata),
    .uart_rsp_err_i   (uart_rsp_err)
  );

  sys_ctrl i_sys_ctrl (
    .periphl_clk_i (periphl_clk_i),
    .rst_i         (rst_i),
    .req_i         (sys_req),
    .we_i          (sys_we),
    .addr_i        (sys_addr),
    .wdata_i       (sys_wdata),
    .rsp_valid_o   (sys_rsp_valid),
    .rsp_rdata_o   (sys_rsp_rdata),
    .rsp_err_o     (sys_rsp_err)
  );

  uart_regs i_uart_regs (
    .periphl_clk_i (periphl_clk_i),
    .rst_i         (rst_i),
    .req_i         (uart_req),
    .we_i          (uart_we),
    .addr_i        (uart_addr),
    .wdata_i       (uart_wdata),
    .rsp_valid_o   (uart_rsp_valid),
    .rsp_rdata_o   (uart_rsp_rdata),
    .rsp_err_o     (uart_rsp_err),
    .uart_rx_i     (uart_rx_i),
    .uart_tx_o     (uart_tx_o)
  );

endmodule

//--- tests/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 2;

  // Free running, period 4
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

//--- tests/tb_dual_helix_periph.sv
module tb_dual_helix_periph;

  localparam int RESET_CYCLES  = 8;
  localparam int DRIVE_DLY     = 1;
  localparam int READY_TIMEOUT = 16;
  localparam int START_TIMEOUT = 64;
  localparam int POLL_LIMIT    = 100;
  localparam int RUN_LIMIT     = 5000;
  localparam int CPB           = dhs_pkg::UART_CLKS_PER_BIT;
  localparam int AW            = dhs_pkg::DHS_ADDRW;
  localparam int DW            = dhs_pkg::DHS_DATAW;
  localparam int RB            = dhs_pkg::REGION_BITS;

  logic          clk;
  logic          rst;
  logic          psel;
  logic          penable;
  logic [AW-1:0] paddr;
  logic          pwrite;
  logic [DW-1:0] pwdata;
  logic          pready;
  logic [DW-1:0] prdata;
  logic          pslverr;
  logic          uart_rx;
  logic          uart_tx;

  // Register addresses as seen from APB
  logic [AW-1:0] id_addr;
  logic [AW-1:0] scr0_addr;
  logic [AW-1:0] scr1_addr;
  logic [AW-1:0] udata_addr;
  logic [AW-1:0] ustat_addr;

  // Shadow state for the expected values
  logic [DW-1:0] scratch0_sh = '0;
  logic [DW-1:0] scratch1_sh = '0;
  logic          tx_busy_sh  = 1'b0;
  logic          rx_full_sh  = 1'b0;
  logic [7:0]    rx_byte_sh  = '0;

  integer        seed = 69;
  int unsigned   value_err_cnt = 0;
  int unsigned   timeout_cnt = 0;
  logic [DW-1:0] word0;
  logic [DW-1:0] word1;
  logic [7:0]    tx_byte;
  logic [7:0]    tx_byte2;
  logic [7:0]    rx_byte;
  logic [7:0]    mon_byte;
  logic          mon_seen;

  // Pending comparisons
  string         name_q[$];
  logic [DW-1:0] exp_q[$];
  logic [DW-1:0] act_q[$];
  time           time_q[$];
  string         chk_name;
  logic [DW-1:0] chk_exp;
  logic [DW-1:0] chk_act;
  time           chk_time;

  tb_clk_gen i_tb_clk_gen (
    .clk_o (clk)
  );

  dual_helix_periph i_dual_helix_periph (
    .periphl_clk_i (clk),
    .rst_i         (rst),
    .apb_psel_i    (psel),
    .apb_penable_i (penable),
    .apb_paddr_i   (paddr),
    .apb_pwrite_i  (pwrite),
    .apb_pwdata_i  (pwdata),
    .apb_pready_o  (pready),
    .apb_prdata_o  (prdata),
    .apb_pslverr_o (pslverr),
    .uart_rx_i     (uart_rx),
    .uart_tx_o     (uart_tx)
  );

  function automatic logic [AW-1:0] region_addr(input logic [AW-1:0] base,
                                                input logic [RB-1:0] ofs);
    return base | {{(AW - RB){1'b0}}, ofs};
  endfunction

  assign id_addr    = region_addr(dhs_pkg::SYS_CTRL_BASE, dhs_pkg::SYS_ID_OFS);
  assign scr0_addr  = region_addr(dhs_pkg::SYS_CTRL_BASE, dhs_pkg::SYS_SCRATCH0_OFS);
  assign scr1_addr  = region_addr(dhs_pkg::SYS_CTRL_BASE, dhs_pkg::SYS_SCRATCH1_OFS);
  assign udata_addr = region_addr(dhs_pkg::UART_BASE, dhs_pkg::UART_DATA_OFS);
  assign ustat_addr = region_addr(dhs_pkg::UART_BASE, dhs_pkg::UART_STATUS_OFS);

  ////////////////////////////////////////////////////////////
  // Reference model of the register map
  ////////////////////////////////////////////////////////////

  function automatic void expected_read(input logic [AW-1:0] addr, input logic write,
                                        output logic [DW-1:0] data, output logic err,
                                        output logic data_known);
    logic [AW-RB-1:0] tag;
    logic [RB-1:0]    ofs;
    tag        = addr[AW-1:RB];
    ofs        = addr[RB-1:0];
    data       = '0;
    err        = 1'b1;
    data_known = !write;
    if (tag == dhs_pkg::SYS_CTRL_BASE[AW-1:RB]) begin
      case (ofs)
        dhs_pkg::SYS_ID_OFS: begin
          data = dhs_pkg::SOC_ID;
          err  = write;
        end
        dhs_pkg::SYS_SCRATCH0_OFS: begin
          data = scratch0_sh;
          err  = 1'b0;
        end
        dhs_pkg::SYS_SCRATCH1_OFS: begin
          data = scratch1_sh;
          err  = 1'b0;
        end
        default: err = 1'b1;
      endcase
    end else if (tag == dhs_pkg::UART_BASE[AW-1:RB]) begin
      case (ofs)
        dhs_pkg::UART_DATA_OFS: begin
          data = {{(DW - 8){1'b0}}, rx_byte_sh};
          err  = write && tx_busy_sh;
        end
        dhs_pkg::UART_STATUS_OFS: begin
          data = {{(DW - 2){1'b0}}, rx_full_sh, tx_busy_sh};
          err  = write;
        end
        default: err = 1'b1;
      endcase
    end else begin
      // Unmapped, zero data on reads and writes
      data_known = 1'b1;
    end
  endfunction

  function automatic void post_check(input string name, input logic [DW-1:0] exp_val,
                                     input logic [DW-1:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
    time_q.push_back($time);
  endfunction

  // Comparison process
  always @(posedge clk) begin
    while (exp_q.size() > 0) begin
      chk_name = name_q.pop_front();
      chk_exp  = exp_q.pop_front();
      chk_act  = act_q.pop_front();
      chk_time = time_q.pop_front();
      if (chk_act !== chk_exp) begin
        $display("** Error @ %0t: %s expected %h, got %h", chk_time, chk_name, chk_exp, chk_act);
        value_err_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus and serial tasks
  ////////////////////////////////////////////////////////////

  task automatic apb_access(input logic [AW-1:0] addr, input logic write,
                            input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                            output logic err);
    int unsigned cycles;
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY penable = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!pready && cycles < READY_TIMEOUT);
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("APB access to address %h got no pready before the timeout", addr);
      timeout_cnt++;
    end else begin
      post_check("apb access phase cycles", 2, cycles);
    end
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_check(input logic [AW-1:0] addr, input logic write,
                           input logic [DW-1:0] wdata);
    logic [DW-1:0] exp_data;
    logic [DW-1:0] act_data;
    logic          exp_err;
    logic          act_err;
    logic          data_known;
    expected_read(addr, write, exp_data, exp_err, data_known);
    apb_access(addr, write, wdata, act_data, act_err);
    post_check("apb_pslverr_o", 32'(exp_err), 32'(act_err));
    if (data_known) begin
      post_check("apb_prdata_o", exp_data, act_data);
    end
    // Keep the shadow state in step with accepted accesses
    if (write && !exp_err) begin
      if (addr == scr0_addr) scratch0_sh = wdata;
      if (addr == scr1_addr) scratch1_sh = wdata;
      if (addr == udata_addr) tx_busy_sh = 1'b1;
    end
    if (!write && addr == udata_addr) begin
      rx_full_sh = 1'b0;
    end
  endtask

  task automatic poll_status(input logic [DW-1:0] mask, input logic [DW-1:0] want,
                             input string what);
    logic [DW-1:0] rd;
    logic          err;
    int unsigned   tries;
    logic          hit;
    tries = 0;
    hit   = 1'b0;
    while (!hit && tries < POLL_LIMIT) begin
      apb_access(ustat_addr, 1'b0, '0, rd, err);
      tries++;
      hit = ((rd & mask) == want) && !err;
    end
    if (!hit) begin
      $display("UART status never showed %s before the timeout", what);
      timeout_cnt++;
    end
  endtask

  // Drives one 8N1 frame onto the receiver input
  task automatic send_serial(input logic [7:0] data);
    @(posedge clk);
    #DRIVE_DLY uart_rx = 1'b0;
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge clk);
      #DRIVE_DLY uart_rx = data[i];
    end
    repeat (CPB) @(posedge clk);
    #DRIVE_DLY uart_rx = 1'b1;
    repeat (CPB) @(posedge clk);
  endtask

  // Decodes one frame from the transmitter, sampling near mid-bit
  task automatic monitor_tx(output logic [7:0] data, output logic seen);
    int unsigned wait_cnt;
    data     = '0;
    seen     = 1'b0;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (uart_tx !== 1'b0 && wait_cnt < START_TIMEOUT);
    if (uart_tx !== 1'b0) begin
      $display("No start bit appeared on uart_tx_o before the timeout");
      timeout_cnt++;
    end else begin
      repeat (CPB / 2) @(negedge clk);
      post_check("uart_tx_o start bit", 0, 32'(uart_tx));
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        data[i] = uart_tx;
      end
      repeat (CPB) @(negedge clk);
      post_check("uart_tx_o stop bit", 1, 32'(uart_tx));
      seen = 1'b1;
    end
  endtask

  task automatic report_and_finish();
    $display("Error counts: %0d wrong values, %0d timeouts", value_err_cnt, timeout_cnt);
    if ((value_err_cnt + timeout_cnt) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    paddr   = '0;
    pwrite  = 1'b0;
    pwdata  = '0;
    uart_rx = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY rst = 1'b0;

    @(negedge clk);
    post_check("apb_pready_o", 0, 32'(pready));
    post_check("apb_pslverr_o", 0, 32'(pslverr));
    post_check("uart_tx_o", 1, 32'(uart_tx));

    // System controller
    apb_check(id_addr, 1'b0, '0);
    apb_check(scr0_addr, 1'b0, '0);
    word0 = $random(seed);
    word1 = $random(seed);
    apb_check(scr0_addr, 1'b1, word0);
    apb_check(scr1_addr, 1'b1, word1);
    apb_check(scr0_addr, 1'b0, '0);
    apb_check(scr1_addr, 1'b0, '0);
    apb_check(id_addr, 1'b1, $random(seed));
    apb_check(id_addr, 1'b0, '0);
    apb_check(region_addr(dhs_pkg::SYS_CTRL_BASE, 12'h00C), 1'b0, '0);

    // Unmapped space
    apb_check(32'h2000_0000, 1'b0, '0);
    apb_check(32'h2000_0000, 1'b1, $random(seed));
    apb_check(32'h1000_2000, 1'b0, '0);

    // UART transmit with a refused write in the middle of the frame
    tx_byte  = 8'($random(seed));
    tx_byte2 = 8'($random(seed));
    fork
      monitor_tx(mon_byte, mon_seen);
      begin
        apb_check(udata_addr, 1'b1, {{(DW - 8){1'b0}}, tx_byte});
        apb_check(ustat_addr, 1'b0, '0);
        apb_check(udata_addr, 1'b1, {{(DW - 8){1'b0}}, tx_byte2});
      end
    join
    if (mon_seen) begin
      post_check("uart_tx_o byte", 32'(tx_byte), 32'(mon_byte));
    end
    poll_status(32'h1, 32'h0, "an idle transmitter");
    tx_busy_sh = 1'b0;
    apb_check(ustat_addr, 1'b0, '0);

    // UART receive
    rx_byte = 8'($random(seed));
    send_serial(rx_byte);
    poll_status(32'h2, 32'h2, "a received byte");
    rx_full_sh = 1'b1;
    rx_byte_sh = rx_byte;
    apb_check(ustat_addr, 1'b0, '0);
    apb_check(udata_addr, 1'b0, '0);
    apb_check(ustat_addr, 1'b0, '0);

    // Let the comparison process drain
    repeat (2) @(posedge clk);
    report_and_finish();
  end

  // Run limit
  initial begin
    for (int i = 0; i < RUN_LIMIT; i++) begin
      @(posedge clk);
    end
    $display("The run did not complete within its cycle limit");
    timeout_cnt++;
    report_and_finish();
  end

endmodule

//--- verilog.f
source/dhs_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/sys_ctrl.sv
source/periph_link.sv
source/apb_slave_port.sv
source/dual_helix_periph.sv
tests/tb_clk_gen.sv
tests/tb_dual_helix_periph.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_dual_helix_periph -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/tb_sim)"
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF '*** PASSED ***'; then
  exit 0
fi
exit 1
